/* common/cpu_pkg.sv */
// binary mode only, no reset vector, only imm and zero page operand modes are defined
`default_nettype none

package cpu_pkg;

  localparam int ADDR_W = 16;
  localparam int DATA_W = 8;

  // bit positions in P
  localparam int FLAG_N = 7;
  localparam int FLAG_V = 6;
  localparam int FLAG_Z = 1;
  localparam int FLAG_C = 0;

  localparam logic [7:0] P_RESET = 8'h20; // bit 5 always reads as one

  // cc field of the opcode
  localparam logic [1:0] GROUP_XY  = 2'b00; // ldy sty cpx cpy jmp
  localparam logic [1:0] GROUP_ACC = 2'b01;
  localparam logic [1:0] GROUP_RMW = 2'b10; // ldx stx

  // bbb field
  localparam logic [2:0] AMODE_IMM    = 3'b010; // group acc
  localparam logic [2:0] AMODE_IMM_XY = 3'b000; // immediate in groups xy and rmw
  localparam logic [2:0] AMODE_ZP     = 3'b001; // same in every group

  typedef enum logic [2:0] {
    st_fetch,
    st_operand,
    st_abs_hi,    // high byte of jmp target
    st_mem_read,
    st_mem_write,
    st_execute
  } cpu_state_e;

  typedef enum logic [2:0] {
    pass_b,
    op_or,
    op_and,
    op_eor,
    add,
    sub,          // a + ~b + cin
    inc,
    dec
  } alu_op_e;

  typedef enum logic [1:0] {
    sel_none,
    sel_a,
    sel_x,
    sel_y
  } reg_sel_e;

  // one opcode byte, seen as aaa/bbb/cc or as two nibbles
  typedef union packed {
    struct packed {
      logic [2:0] op_aaa;
      logic [2:0] op_bbb;
      logic [1:0] op_cc;
    } f;
    struct packed {
      logic [3:0] op_hi;
      logic [3:0] op_lo;
    } n;
  } opcode_u;

endpackage

`default_nettype wire

/* common/alu_if.sv */
// combinational path only, results follow the operands in the same cycle
`timescale 1ns/1ps
`default_nettype none

interface alu_if;
  logic [cpu_pkg::DATA_W-1:0] a;
  logic [cpu_pkg::DATA_W-1:0] b;
  logic                       cin;
  cpu_pkg::alu_op_e           op;
  logic [cpu_pkg::DATA_W-1:0] result;
  logic                       cout;
  logic                       ovf;

  modport src (output a, b, cin, op, input result, cout, ovf);
  modport alu (input a, b, cin, op, output result, cout, ovf);
endinterface

`default_nettype wire

/* hdl/program_counter.sv */
// load has priority over inc when both are set in one cycle
`timescale 1ns/1ps
`default_nettype none

module program_counter (
  input  wire                        CLK,
  input  wire                        R,
  input  wire                        inc,
  input  wire                        load,
  input  wire  [cpu_pkg::ADDR_W-1:0] load_value,
  output logic [cpu_pkg::ADDR_W-1:0] pc
);

  always_ff @(posedge CLK or posedge R) begin
    if (R) begin
      pc <= '0;
    end else if (load) begin
      pc <= load_value; // jmp
    end else if (inc) begin
      pc <= pc + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* control/instr_decode.sv */
// combinational decode of the reduced opcode set, anything else reads as nop
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
  input  cpu_pkg::opcode_u   opcode,
  output logic               is_load,
  output logic               is_store,
  output logic               is_alu,
  output logic               is_compare,
  output logic               is_incdec,
  output logic               is_transfer,
  output logic               is_flag_op,
  output logic               is_jmp,
  output logic               is_nop,
  output logic               uses_operand,
  output logic               uses_zp,
  output cpu_pkg::alu_op_e   alu_op,
  output cpu_pkg::reg_sel_e  src_sel,
  output cpu_pkg::reg_sel_e  dst_sel
);

  logic [2:0] aaa;
  logic [1:0] cc;
  logic [3:0] hi;
  logic [3:0] lo;
  logic       amode_imm;
  logic       amode_zp;
  logic       row_ok;
  logic       cmp_xy;
  logic       inx, iny, dex, dey;
  logic       tax, txa, tay, tya;
  cpu_pkg::reg_sel_e row_reg;

  assign aaa = opcode.f.op_aaa;
  assign cc  = opcode.f.op_cc;
  assign hi  = opcode.n.op_hi;
  assign lo  = opcode.n.op_lo;

  assign amode_imm = (cc == cpu_pkg::GROUP_ACC) ? opcode.f.op_bbb == cpu_pkg::AMODE_IMM
                                                : opcode.f.op_bbb == cpu_pkg::AMODE_IMM_XY;
  assign amode_zp  = opcode.f.op_bbb == cpu_pkg::AMODE_ZP;
  assign row_ok    = (amode_imm || amode_zp) && cc != 2'b11;

  // register named by the group, a x or y
  assign row_reg = (cc == cpu_pkg::GROUP_ACC) ? cpu_pkg::sel_a :
                   (cc == cpu_pkg::GROUP_RMW) ? cpu_pkg::sel_x : cpu_pkg::sel_y;

  assign is_load  = row_ok && aaa == 3'b101;
  assign is_store = row_ok && aaa == 3'b100 && amode_zp;
  assign is_alu   = row_ok && cc == cpu_pkg::GROUP_ACC &&
                    (aaa[2] == 1'b0 || aaa == 3'b111); // ora and eor adc sbc
  assign cmp_xy   = row_ok && cc == cpu_pkg::GROUP_XY && aaa[2:1] == 2'b11 && amode_imm;
  assign is_compare = cmp_xy || (row_ok && cc == cpu_pkg::GROUP_ACC && aaa == 3'b110);

  // single byte ops by nibble
  assign inx = hi == 4'hE && lo == 4'h8;
  assign iny = hi == 4'hC && lo == 4'h8;
  assign dex = hi == 4'hC && lo == 4'hA;
  assign dey = hi == 4'h8 && lo == 4'h8;
  assign tax = hi == 4'hA && lo == 4'hA;
  assign txa = hi == 4'h8 && lo == 4'hA;
  assign tay = hi == 4'hA && lo == 4'h8;
  assign tya = hi == 4'h9 && lo == 4'h8;

  assign is_incdec   = inx || iny || dex || dey;
  assign is_transfer = tax || txa || tay || tya;
  assign is_flag_op  = lo == 4'h8 && (hi == 4'h1 || hi == 4'h3);
  assign is_jmp      = hi == 4'h4 && lo == 4'hC;
  assign is_nop      = !(is_load || is_store || is_alu || is_compare || is_incdec ||
                         is_transfer || is_flag_op || is_jmp);

  assign uses_operand = is_load || is_store || is_alu || is_compare || is_jmp;
  assign uses_zp      = (is_load || is_store || is_alu || is_compare) && amode_zp;

  always_comb begin
    alu_op  = cpu_pkg::pass_b;
    src_sel = cpu_pkg::sel_none;
    dst_sel = cpu_pkg::sel_none;
    if (is_alu) begin
      src_sel = cpu_pkg::sel_a;
      dst_sel = cpu_pkg::sel_a;
      case (aaa)
        3'b000:  alu_op = cpu_pkg::op_or;
        3'b001:  alu_op = cpu_pkg::op_and;
        3'b010:  alu_op = cpu_pkg::op_eor;
        3'b011:  alu_op = cpu_pkg::add;
        default: alu_op = cpu_pkg::sub;
      endcase
    end else if (is_compare) begin
      alu_op  = cpu_pkg::sub;
      src_sel = cmp_xy ? (hi == 4'hE ? cpu_pkg::sel_x : cpu_pkg::sel_y) : cpu_pkg::sel_a;
    end else if (is_load) begin
      dst_sel = row_reg;
    end else if (is_store) begin
      src_sel = row_reg;
    end else if (is_incdec) begin
      alu_op  = (inx || iny) ? cpu_pkg::inc : cpu_pkg::dec;
      src_sel = (inx || dex) ? cpu_pkg::sel_x : cpu_pkg::sel_y;
      dst_sel = src_sel;
    end else if (is_transfer) begin
      src_sel = (tax || tay) ? cpu_pkg::sel_a : (txa ? cpu_pkg::sel_x : cpu_pkg::sel_y);
      dst_sel = (txa || tya) ? cpu_pkg::sel_a : (tax ? cpu_pkg::sel_x : cpu_pkg::sel_y);
    end
  end

endmodule

`default_nettype wire

/* control/cpu_sequencer.sv */
// no request in the first cycle after reset, request held stable until mem_ready
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer (
  input  wire                        CLK,
  input  wire                        R,
  input  wire                        mem_ready,
  input  wire  [cpu_pkg::DATA_W-1:0] mem_rdata,
  input  wire  [cpu_pkg::ADDR_W-1:0] pc,
  input  wire                        is_load,
  input  wire                        is_store,
  input  wire                        is_alu,
  input  wire                        is_compare,
  input  wire                        is_incdec,
  input  wire                        is_transfer,
  input  wire                        is_flag_op,
  input  wire                        is_jmp,
  input  wire                        is_nop,
  input  wire                        uses_operand,
  input  wire                        uses_zp,
  input  wire  [cpu_pkg::DATA_W-1:0] store_data,
  output cpu_pkg::opcode_u           opcode,
  output logic                       mem_valid,
  output logic                       mem_we,
  output logic                       sync,
  output logic [cpu_pkg::ADDR_W-1:0] mem_addr,
  output logic [cpu_pkg::DATA_W-1:0] mem_wdata,
  output logic                       pc_inc,
  output logic                       pc_load,
  output logic [cpu_pkg::ADDR_W-1:0] jump_target,
  output logic [cpu_pkg::DATA_W-1:0] operand,
  output logic                       exec_en,
  output logic                       flag_op_en
);

  cpu_pkg::cpu_state_e        state;
  cpu_pkg::opcode_u           opcode_q;
  logic [cpu_pkg::DATA_W-1:0] operand_q;  // imm value or zp address
  logic                       run;
  logic                       xfer;
  logic                       zp_access;
  logic                       has_result;

  assign zp_access = state == cpu_pkg::st_mem_read || state == cpu_pkg::st_mem_write;
  assign mem_valid = run && state != cpu_pkg::st_execute;
  assign xfer      = mem_valid && mem_ready;
  assign mem_we    = mem_valid && state == cpu_pkg::st_mem_write;
  assign sync      = mem_valid && state == cpu_pkg::st_fetch;
  assign mem_addr  = zp_access ? {8'h00, operand_q} : pc;
  assign mem_wdata = mem_we ? store_data : '0;

  // decode sees the incoming byte while fetching
  assign opcode = (state == cpu_pkg::st_fetch) ? cpu_pkg::opcode_u'(mem_rdata) : opcode_q;
  assign operand = (state == cpu_pkg::st_mem_read) ? mem_rdata : operand_q;

  assign jump_target = {mem_rdata, operand_q};
  assign pc_inc  = xfer && (state == cpu_pkg::st_fetch || state == cpu_pkg::st_operand ||
                            state == cpu_pkg::st_abs_hi);
  assign pc_load = xfer && state == cpu_pkg::st_abs_hi;

  assign has_result = is_load || is_alu || is_compare || is_incdec || is_transfer;
  assign exec_en    = has_result && (state == cpu_pkg::st_execute ||
                                     (state == cpu_pkg::st_mem_read && xfer));
  assign flag_op_en = xfer && state == cpu_pkg::st_fetch && is_flag_op;

  always_ff @(posedge CLK or posedge R) begin
    if (R) begin
      state <= cpu_pkg::st_fetch;
      run   <= 1'b0;
    end else begin
      run <= 1'b1;
      case (state)
        cpu_pkg::st_fetch: begin
          if (xfer) begin
            if (is_nop || is_flag_op) begin
              state <= cpu_pkg::st_fetch;
            end else if (uses_operand) begin
              state <= cpu_pkg::st_operand;
            end else begin
              state <= cpu_pkg::st_execute; // inc/dec and transfers
            end
          end
        end
        cpu_pkg::st_operand: begin
          if (xfer) begin
            if (is_jmp) begin
              state <= cpu_pkg::st_abs_hi;
            end else if (uses_zp) begin
              state <= is_store ? cpu_pkg::st_mem_write : cpu_pkg::st_mem_read;
            end else begin
              state <= cpu_pkg::st_execute;
            end
          end
        end
        cpu_pkg::st_execute: state <= cpu_pkg::st_fetch;
        default: begin
          if (xfer) begin
            state <= cpu_pkg::st_fetch; // abs_hi, mem_read, mem_write
          end
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (xfer && state == cpu_pkg::st_fetch) begin
      opcode_q <= cpu_pkg::opcode_u'(mem_rdata);
    end
    if (xfer && state == cpu_pkg::st_operand) begin
      operand_q <= mem_rdata;
    end
  end

endmodule

`default_nettype wire

/* datapath/alu8.sv */
// binary arithmetic only, cout after dec is not a borrow flag
`timescale 1ns/1ps
`default_nettype none

module alu8 (
  alu_if.alu alu
);

  logic [7:0] b_add;
  logic       c_add;
  logic [8:0] sum;
  logic       arith;

  // one adder serves add, sub, inc and dec
  always_comb begin
    b_add = alu.b;
    c_add = alu.cin;
    case (alu.op)
      cpu_pkg::sub: b_add = ~alu.b;
      cpu_pkg::inc: begin
        b_add = 8'h00;
        c_add = 1'b1;
      end
      cpu_pkg::dec: begin
        b_add = 8'hFF;
        c_add = 1'b0;
      end
      default: begin
      end
    endcase
  end

  assign sum   = {1'b0, alu.a} + {1'b0, b_add} + {8'h00, c_add};
  assign arith = alu.op == cpu_pkg::add || alu.op == cpu_pkg::sub;

  always_comb begin
    case (alu.op)
      cpu_pkg::pass_b: alu.result = alu.b;
      cpu_pkg::op_or:  alu.result = alu.a | alu.b;
      cpu_pkg::op_and: alu.result = alu.a & alu.b;
      cpu_pkg::op_eor: alu.result = alu.a ^ alu.b;
      default:         alu.result = sum[7:0];
    endcase
  end

  assign alu.cout = sum[8];
  // same sign in, other sign out
  assign alu.ovf  = arith && (alu.a[7] == b_add[7]) && (sum[7] != alu.a[7]);

endmodule

`default_nettype wire

/* datapath/reg_file.sv */
// compares update flags only, V is left alone by compares and inc/dec
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire                        CLK,
  input  wire                        R,
  input  wire                        exec_en,
  input  wire                        flag_op_en,
  input  wire                        set_carry,
  input  wire  [cpu_pkg::DATA_W-1:0] operand,
  input  cpu_pkg::reg_sel_e          src_sel,
  input  cpu_pkg::reg_sel_e          dst_sel,
  input  cpu_pkg::alu_op_e           alu_op,
  input  wire                        is_compare,
  input  wire                        is_load,
  alu_if.src                         alu,
  output logic [cpu_pkg::DATA_W-1:0] store_data,
  output logic [cpu_pkg::DATA_W-1:0] reg_a,
  output logic [cpu_pkg::DATA_W-1:0] reg_x,
  output logic [cpu_pkg::DATA_W-1:0] reg_y,
  output logic [cpu_pkg::DATA_W-1:0] reg_p
);

  logic [cpu_pkg::DATA_W-1:0] src_val;
  logic                       arith;

  always_comb begin
    case (src_sel)
      cpu_pkg::sel_a: src_val = reg_a;
      cpu_pkg::sel_x: src_val = reg_x;
      cpu_pkg::sel_y: src_val = reg_y;
      default:        src_val = '0;
    endcase
  end

  assign arith      = alu_op == cpu_pkg::add || alu_op == cpu_pkg::sub;
  assign store_data = src_val;
  assign alu.a      = src_val;
  assign alu.b      = (alu_op == cpu_pkg::pass_b && !is_load) ? src_val : operand; // transfers
  assign alu.op     = alu_op;
  assign alu.cin    = arith && (is_compare || reg_p[cpu_pkg::FLAG_C]);

  always_ff @(posedge CLK or posedge R) begin
    if (R) begin
      reg_a <= '0;
      reg_x <= '0;
      reg_y <= '0;
      reg_p <= cpu_pkg::P_RESET;
    end else if (exec_en) begin
      if (!is_compare) begin
        case (dst_sel)
          cpu_pkg::sel_a: reg_a <= alu.result;
          cpu_pkg::sel_x: reg_x <= alu.result;
          cpu_pkg::sel_y: reg_y <= alu.result;
          default: begin
          end
        endcase
      end
      reg_p[cpu_pkg::FLAG_N] <= alu.result[7];
      reg_p[cpu_pkg::FLAG_Z] <= alu.result == '0;
      if (arith) begin
        reg_p[cpu_pkg::FLAG_C] <= alu.cout;  // compares land here too
      end
      if (arith && !is_compare) begin
        reg_p[cpu_pkg::FLAG_V] <= alu.ovf;
      end
    end else if (flag_op_en) begin
      reg_p[cpu_pkg::FLAG_C] <= set_carry; // clc / sec
    end
  end

endmodule

`default_nettype wire

/* hdl/cpu_top.sv */
// memory is external on a valid/ready port, pc starts at 0x0000, one instruction at a time
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
  input  wire                        CLK,
  input  wire                        R,
  output logic                       mem_valid,
  output logic                       mem_we,
  output logic [cpu_pkg::ADDR_W-1:0] mem_addr,
  output logic [cpu_pkg::DATA_W-1:0] mem_wdata,
  input  wire                        mem_ready,
  input  wire  [cpu_pkg::DATA_W-1:0] mem_rdata,
  output logic                       sync,
  output logic [cpu_pkg::DATA_W-1:0] reg_a,
  output logic [cpu_pkg::DATA_W-1:0] reg_x,
  output logic [cpu_pkg::DATA_W-1:0] reg_y,
  output logic [cpu_pkg::DATA_W-1:0] reg_p
);

  logic [cpu_pkg::ADDR_W-1:0] pc;
  logic [cpu_pkg::ADDR_W-1:0] jump_target;
  logic                       pc_inc;
  logic                       pc_load;
  cpu_pkg::opcode_u           opcode;
  logic                       is_load;
  logic                       is_store;
  logic                       is_alu;
  logic                       is_compare;
  logic                       is_incdec;
  logic                       is_transfer;
  logic                       is_flag_op;
  logic                       is_jmp;
  logic                       is_nop;
  logic                       uses_operand;
  logic                       uses_zp;
  cpu_pkg::alu_op_e           alu_op;
  cpu_pkg::reg_sel_e          src_sel;
  cpu_pkg::reg_sel_e          dst_sel;
  logic [cpu_pkg::DATA_W-1:0] operand;
  logic [cpu_pkg::DATA_W-1:0] store_data;
  logic                       exec_en;
  logic                       flag_op_en;

  alu_if alu_bus ();

  cpu_sequencer u_seq (.*);

  program_counter u_pc (
    .CLK        (CLK),
    .R          (R),
    .inc        (pc_inc),
    .load       (pc_load),
    .load_value (jump_target),
    .pc         (pc)
  );

  instr_decode u_dec (.*);

  reg_file u_regs (
    .*,
    .set_carry (opcode.f.op_aaa[0]), // sec is 0x38, clc is 0x18
    .alu       (alu_bus.src)
  );

  alu8 u_alu (.alu(alu_bus.alu));

endmodule

`default_nettype wire

/* dv/cpu_properties.sv */
// handshake rules only, checked while R is low
`timescale 1ns/1ps
`default_nettype none

module cpu_properties (
  input wire        CLK,
  input wire        R,
  input wire        mem_valid,
  input wire        mem_ready,
  input wire        mem_we,
  input wire        sync,
  input wire [15:0] mem_addr,
  input wire [7:0]  mem_wdata
);

  a_we_needs_valid: assert property (@(posedge CLK) disable iff (R) mem_we |-> mem_valid)
    else $error("mem_we seen without mem_valid");

  // request frozen while the memory stalls
  a_req_stable: assert property (@(posedge CLK) disable iff (R)
    (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_addr) && $stable(mem_we) &&
                                   $stable(mem_wdata)))
    else $error("memory request changed under back-pressure");

  a_sync_no_write: assert property (@(posedge CLK) disable iff (R) !(sync && mem_we))
    else $error("sync raised during a write");

endmodule

bind cpu_top cpu_properties u_props (.*);

`default_nettype wire

/* dv/cpu_checker.sv */
// row n-1 is checked at the n-th opcode fetch, flags compared as {N,Z,C,V}
`timescale 1ns/1ps
`default_nettype none

module cpu_checker #(
  parameter int NROWS = 1
) (
  input  wire        CLK,
  input  wire        R,
  input  wire        mem_valid,
  input  wire        mem_ready,
  input  wire        mem_we,
  input  wire        sync,
  input  wire [15:0] mem_addr,
  input  wire [7:0]  mem_wdata,
  input  wire [7:0]  reg_a,
  input  wire [7:0]  reg_x,
  input  wire [7:0]  reg_y,
  input  wire [7:0]  reg_p,
  input  logic [7:0] exp_a [NROWS],
  input  logic [7:0] exp_x [NROWS],
  input  logic [7:0] exp_y [NROWS],
  input  logic [3:0] exp_f [NROWS],
  input  logic       exp_st [NROWS],
  input  logic [7:0] exp_sa [NROWS],
  input  logic [7:0] exp_sd [NROWS],
  input  logic [15:0] exp_next [NROWS],
  output int         pass_cnt,
  output int         fail_cnt
);

  int   seen;
  int   idx;
  logic row_bad;
  logic wrote;

  task automatic compare_value(input string what, input int i, input logic [15:0] got,
                               input logic [15:0] want);
    if (got !== want) begin
      $display("FAILED at %0t: instr %0d %s is %h, expected %h", $time, i, what, got, want);
      row_bad = 1'b1;
    end
  endtask

  task automatic finish_row(input int i);
    compare_value("A", i, {8'h00, reg_a}, {8'h00, exp_a[i]});
    compare_value("X", i, {8'h00, reg_x}, {8'h00, exp_x[i]});
    compare_value("Y", i, {8'h00, reg_y}, {8'h00, exp_y[i]});
    compare_value("NZCV", i, {12'h000, reg_p[7], reg_p[1], reg_p[0], reg_p[6]},
                  {12'h000, exp_f[i]});
    compare_value("next fetch address", i, mem_addr, exp_next[i]);
    if (exp_st[i] && !wrote) begin
      $display("instr %0d never wrote to memory", i);
      row_bad = 1'b1;
    end
    if (row_bad) begin
      fail_cnt++;
    end else begin
      pass_cnt++;
      $display("instr %0d ok", i);
    end
  endtask

  always @(posedge CLK) begin
    if (R) begin
      seen     = 0;
      pass_cnt = 0;
      fail_cnt = 0;
      row_bad  = 1'b0;
      wrote    = 1'b0;
    end else begin
      if (mem_valid && mem_ready && mem_we) begin
        idx = seen - 1;
        if (idx < 0 || idx >= NROWS || !exp_st[idx]) begin
          $display("unexpected memory write to %h", mem_addr);
          row_bad = 1'b1;
        end else begin
          compare_value("store address", idx, mem_addr, {8'h00, exp_sa[idx]});
          compare_value("store data", idx, {8'h00, mem_wdata}, {8'h00, exp_sd[idx]});
          wrote = 1'b1;
        end
      end
      if (mem_valid && mem_ready && sync) begin
        if (seen >= 1 && seen <= NROWS) begin
          finish_row(seen - 1);
        end
        seen++;
        wrote   = 1'b0;
        row_bad = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* dv/tb_cpu.sv */
// program loaded at 0x0000, random mem_ready stalls, up to 200 cycles per fetch
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

  localparam int NROWS = 38;

  logic        CLK = 1'b0;
  logic        R;
  logic        mem_ready;
  logic [7:0]  mem_rdata;
  logic        mem_valid, mem_we, sync;
  logic [15:0] mem_addr;
  logic [7:0]  mem_wdata, reg_a, reg_x, reg_y, reg_p;

  logic [7:0]  mem [0:65535];
  logic [7:0]  t_op [NROWS];
  logic [7:0]  t_b1 [NROWS];
  logic [7:0]  t_b2 [NROWS];
  int          t_len [NROWS];
  logic [7:0]  exp_a [NROWS];
  logic [7:0]  exp_x [NROWS];
  logic [7:0]  exp_y [NROWS];
  logic [3:0]  exp_f [NROWS];
  logic        exp_st [NROWS];
  logic [7:0]  exp_sa [NROWS];
  logic [7:0]  exp_sd [NROWS];
  logic [15:0] exp_next [NROWS];
  int          nrow;
  int          pass_cnt, fail_cnt;
  logic        wr_pend;
  logic [15:0] wr_addr;
  logic [7:0]  wr_data;
  logic [15:0] lfsr;
  logic        timed_out;

  cpu_top UUT (.*);

  cpu_checker #(.NROWS(NROWS)) u_check (.*);

  always #10 CLK = ~CLK;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // flags given as {N,Z,C,V}, st_data only matters for stores
  task automatic add_row(input logic [7:0] op, input logic [7:0] b1, input logic [7:0] b2,
                         input int len, input logic [7:0] a, input logic [7:0] x,
                         input logic [7:0] y, input logic [3:0] nzcv, input logic st,
                         input logic [7:0] st_data);
    t_op[nrow]   = op;
    t_b1[nrow]   = b1;
    t_b2[nrow]   = b2;
    t_len[nrow]  = len;
    exp_a[nrow]  = a;
    exp_x[nrow]  = x;
    exp_y[nrow]  = y;
    exp_f[nrow]  = nzcv;
    exp_st[nrow] = st;
    exp_sa[nrow] = b1;
    exp_sd[nrow] = st_data;
    nrow++;
  endtask

  task automatic build_table;
    nrow = 0;
    add_row(8'hA9, 8'h00, 8'h00, 2, 8'h00, 8'h00, 8'h00, 4'b0100, 1'b0, 8'h00); // lda #
    add_row(8'hA2, 8'h80, 8'h00, 2, 8'h00, 8'h80, 8'h00, 4'b1000, 1'b0, 8'h00);
    add_row(8'hA0, 8'h7F, 8'h00, 2, 8'h00, 8'h80, 8'h7F, 4'b0000, 1'b0, 8'h00);
    add_row(8'h85, 8'hC0, 8'h00, 2, 8'h00, 8'h80, 8'h7F, 4'b0000, 1'b1, 8'h00); // sta zp
    add_row(8'h86, 8'hC1, 8'h00, 2, 8'h00, 8'h80, 8'h7F, 4'b0000, 1'b1, 8'h80);
    add_row(8'h84, 8'hC2, 8'h00, 2, 8'h00, 8'h80, 8'h7F, 4'b0000, 1'b1, 8'h7F);
    add_row(8'hA5, 8'hC1, 8'h00, 2, 8'h80, 8'h80, 8'h7F, 4'b1000, 1'b0, 8'h00); // lda zp
    add_row(8'hA6, 8'hC2, 8'h00, 2, 8'h80, 8'h7F, 8'h7F, 4'b0000, 1'b0, 8'h00);
    add_row(8'hA4, 8'hC0, 8'h00, 2, 8'h80, 8'h7F, 8'h00, 4'b0100, 1'b0, 8'h00);
    add_row(8'h18, 8'h00, 8'h00, 1, 8'h80, 8'h7F, 8'h00, 4'b0100, 1'b0, 8'h00); // clc
    add_row(8'hA9, 8'h7F, 8'h00, 2, 8'h7F, 8'h7F, 8'h00, 4'b0000, 1'b0, 8'h00);
    add_row(8'h69, 8'h01, 8'h00, 2, 8'h80, 8'h7F, 8'h00, 4'b1001, 1'b0, 8'h00); // overflow
    add_row(8'h38, 8'h00, 8'h00, 1, 8'h80, 8'h7F, 8'h00, 4'b1011, 1'b0, 8'h00); // sec
    add_row(8'hE9, 8'h01, 8'h00, 2, 8'h7F, 8'h7F, 8'h00, 4'b0011, 1'b0, 8'h00);
    add_row(8'h69, 8'h80, 8'h00, 2, 8'h00, 8'h7F, 8'h00, 4'b0110, 1'b0, 8'h00); // carry out
    add_row(8'h09, 8'h0F, 8'h00, 2, 8'h0F, 8'h7F, 8'h00, 4'b0010, 1'b0, 8'h00);
    add_row(8'h29, 8'hF0, 8'h00, 2, 8'h00, 8'h7F, 8'h00, 4'b0110, 1'b0, 8'h00);
    add_row(8'h49, 8'hFF, 8'h00, 2, 8'hFF, 8'h7F, 8'h00, 4'b1010, 1'b0, 8'h00);
    add_row(8'h45, 8'h40, 8'h00, 2, 8'h83, 8'h7F, 8'h00, 4'b1010, 1'b0, 8'h00); // fill 7c
    add_row(8'hC9, 8'h83, 8'h00, 2, 8'h83, 8'h7F, 8'h00, 4'b0110, 1'b0, 8'h00); // cmp
    add_row(8'hE0, 8'h7F, 8'h00, 2, 8'h83, 8'h7F, 8'h00, 4'b0110, 1'b0, 8'h00);
    add_row(8'hC0, 8'h01, 8'h00, 2, 8'h83, 8'h7F, 8'h00, 4'b1000, 1'b0, 8'h00);
    add_row(8'hC8, 8'h00, 8'h00, 1, 8'h83, 8'h7F, 8'h01, 4'b0000, 1'b0, 8'h00); // iny
    add_row(8'h88, 8'h00, 8'h00, 1, 8'h83, 8'h7F, 8'h00, 4'b0100, 1'b0, 8'h00);
    add_row(8'h88, 8'h00, 8'h00, 1, 8'h83, 8'h7F, 8'hFF, 4'b1000, 1'b0, 8'h00); // wraps
    add_row(8'hE8, 8'h00, 8'h00, 1, 8'h83, 8'h80, 8'hFF, 4'b1000, 1'b0, 8'h00);
    add_row(8'hCA, 8'h00, 8'h00, 1, 8'h83, 8'h7F, 8'hFF, 4'b0000, 1'b0, 8'h00);
    add_row(8'hAA, 8'h00, 8'h00, 1, 8'h83, 8'h83, 8'hFF, 4'b1000, 1'b0, 8'h00); // tax
    add_row(8'hA8, 8'h00, 8'h00, 1, 8'h83, 8'h83, 8'h83, 4'b1000, 1'b0, 8'h00);
    add_row(8'hA2, 8'h00, 8'h00, 2, 8'h83, 8'h00, 8'h83, 4'b0100, 1'b0, 8'h00);
    add_row(8'h8A, 8'h00, 8'h00, 1, 8'h00, 8'h00, 8'h83, 4'b0100, 1'b0, 8'h00); // txa
    add_row(8'hA0, 8'h05, 8'h00, 2, 8'h00, 8'h00, 8'h05, 4'b0000, 1'b0, 8'h00);
    add_row(8'h98, 8'h00, 8'h00, 1, 8'h05, 8'h00, 8'h05, 4'b0000, 1'b0, 8'h00); // tya
    add_row(8'h4C, 8'h80, 8'h00, 3, 8'h05, 8'h00, 8'h05, 4'b0000, 1'b0, 8'h00); // jmp 0080
    add_row(8'hEA, 8'h00, 8'h00, 1, 8'h05, 8'h00, 8'h05, 4'b0000, 1'b0, 8'h00); // nop
    add_row(8'hA2, 8'hFF, 8'h00, 2, 8'h05, 8'hFF, 8'h05, 4'b1000, 1'b0, 8'h00);
    add_row(8'hE8, 8'h00, 8'h00, 1, 8'h05, 8'h00, 8'h05, 4'b0100, 1'b0, 8'h00); // inx wraps
    add_row(8'h4C, 8'h84, 8'h00, 3, 8'h05, 8'h00, 8'h05, 4'b0100, 1'b0, 8'h00); // jmp self
  endtask

  // write requests are applied by the memory process on the next falling edge
  always @(posedge CLK) begin
    wr_pend <= mem_valid && mem_ready && mem_we;
    wr_addr <= mem_addr;
    wr_data <= mem_wdata;
  end

  initial begin : memory_model
    logic [15:0] addr;
    mem_ready = 1'b0;
    mem_rdata = 8'h00;
    lfsr      = 16'd18753;
    build_table();
    for (int i = 0; i < 65536; i++) begin
      mem[i] = i[7:0] ^ i[15:8] ^ 8'h3C;
    end
    addr = 16'h0000;
    for (int i = 0; i < NROWS; i++) begin
      mem[addr] = t_op[i];
      if (t_len[i] > 1) mem[addr + 16'd1] = t_b1[i];
      if (t_len[i] > 2) mem[addr + 16'd2] = t_b2[i];
      exp_next[i] = (t_op[i] == 8'h4C) ? {t_b2[i], t_b1[i]} : addr + 16'(t_len[i]);
      addr = exp_next[i];
    end
    forever begin
      @(negedge CLK);
      if (wr_pend) begin
        mem[wr_addr] = wr_data;
      end
      lfsr      = lfsr_next(lfsr);
      mem_ready = lfsr[0];
      mem_rdata = mem[mem_addr];
    end
  end

  task automatic wait_fetch(output logic late);
    int n;
    late = 1'b1;
    for (n = 0; n < 200; n++) begin
      @(posedge CLK);
      if (mem_valid && mem_ready && sync) begin
        late = 1'b0;
        break;
      end
    end
  endtask

  initial begin
    R         = 1'b1;
    timed_out = 1'b0;
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    R = 1'b0;
    for (int i = 0; i <= NROWS; i++) begin
      wait_fetch(timed_out);
      if (timed_out) begin
        $display("no opcode fetch within 200 cycles before instr %0d", i);
        break;
      end
    end
    @(negedge CLK);
    $display("done: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (timed_out || fail_cnt != 0 || pass_cnt != NROWS) begin
      $display("Test failures found");
    end else begin
      $display("All tests passed!");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
common/cpu_pkg.sv
common/alu_if.sv
hdl/program_counter.sv
control/instr_decode.sv
control/cpu_sequencer.sv
datapath/alu8.sv
datapath/reg_file.sv
hdl/cpu_top.sv
dv/cpu_properties.sv
dv/cpu_checker.sv
dv/tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the testbench with Verilator; the log decides pass or fail.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_cpu -o tb_cpu_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/tb_cpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" "$LOG"; then
  exit 1
fi
if ! grep -q "All tests passed!" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
